/* source/rom_loader_pkg.sv */
package rom_loader_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int mem_addr_w = 23;  // SDRAM byte address
	localparam int page_w     = 9;   // Area bit plus 8-bit map index
	localparam int dl_addr_w  = 25;  // Host byte address
	localparam int dl_index_w = 8;

	////////////////////////////////////////////////////////////
	// Fixed ROM pages
	////////////////////////////////////////////////////////////

	localparam logic [page_w-1:0] page_sys_lower  = 9'h000;
	localparam logic [page_w-1:0] page_sys_basic  = 9'h100;
	localparam logic [page_w-1:0] page_sys_amsdos = 9'h107;
	localparam logic [page_w-1:0] page_mf2        = 9'h1FF;

	// Spare page for files whose extension does not parse
	localparam logic [page_w-1:0] page_bad_ext    = 9'h1EE;

	////////////////////////////////////////////////////////////
	// Payload structs
	////////////////////////////////////////////////////////////

	// One byte from the host download stream
	typedef struct packed {
		logic [dl_index_w-1:0] index;
		logic [dl_addr_w-1:0]  addr;
		logic [7:0]            data;
	} dl_byte_t;

	// One SDRAM write
	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic [1:0]            bank;
		logic [7:0]            data;
	} mem_wr_t;

	// Where an expansion file starts, and whether it carries MF2 data
	typedef struct packed {
		logic [page_w-1:0] page;
		logic              combo;
	} start_page_t;

endpackage

/* source/rom_ext_decode.sv */
`timescale 1ns/1ps

module rom_ext_decode import rom_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic [dl_index_w-1:0] dl_index,
	input  logic [15:0]           dl_ext,
	output start_page_t           start
);

	logic        active_d;
	start_page_t decoded;
	logic [4:0]  nib_hi;  // {valid, value}
	logic [4:0]  nib_lo;

	// One hex character to a nibble, bit 4 flags a valid digit
	function automatic logic [4:0] hex_nibble(input logic [7:0] ch);
		logic [4:0] res;
		res = 5'd0;
		if (ch >= "0" && ch <= "9") begin
			res = {1'b1, ch[3:0]};
		end else if (ch >= "A" && ch <= "F") begin
			res = {1'b1, ch[3:0] + 4'd9};
		end
		return res;
	endfunction

	assign nib_hi = hex_nibble(dl_ext[15:8]);
	assign nib_lo = hex_nibble(dl_ext[7:0]);

	always_comb begin
		decoded.page  = page_bad_ext;  // Area bit stays from the spare page
		decoded.combo = 1'b0;
		if (nib_hi[4])
			decoded.page[7:4] = nib_hi[3:0];
		if (nib_lo[4])
			decoded.page[3:0] = nib_lo[3:0];
		if (dl_ext == "ZZ")
			decoded.page = '0;
		if (dl_ext == "Z0") begin
			decoded.page  = '0;
			decoded.combo = 1'b1;  // Expansion ROM followed by MF2 image
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_d <= 1'b0;
			start    <= '0;
		end else begin
			active_d <= dl_active;
			// Latch only at the start of an expansion download
			if (dl_active && !active_d && (|dl_index))
				start <= decoded;
		end
	end

endmodule

/* source/rom_boot_mapper.sv */
`timescale 1ns/1ps

module rom_boot_mapper import rom_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_wr,
	input  dl_byte_t    dl_byte,
	input  start_page_t start,
	input  logic        req_done,
	output logic        dl_wait,
	output logic        req_valid,
	output mem_wr_t     req
);

	start_page_t       start_q;
	logic              start_new;
	logic [page_w-1:0] run_page;
	logic              run_combo;
	logic [page_w-1:0] page_eff;
	logic              combo_eff;

	mem_wr_t           map_req;
	logic              map_drop;
	logic              map_dup;
	logic              dup_q;
	logic              drop_q;
	logic              accept;
	logic              second_wr;
	logic              last_done;

	// A fresh start page takes effect in the same cycle it shows up
	assign start_new = (start != start_q);
	assign page_eff  = start_new ? start.page  : run_page;
	assign combo_eff = start_new ? start.combo : run_combo;

	assign accept    = dl_wr && !dl_wait;
	assign second_wr = req_done && dup_q && (req.bank == 2'd0);
	assign last_done = req_done && !second_wr;

	////////////////////////////////////////////////////////////
	// Byte to SDRAM address
	////////////////////////////////////////////////////////////

	always_comb begin
		map_req.data       = dl_byte.data;
		map_req.addr[13:0] = dl_byte.addr[13:0];
		map_req.addr[22:14] = '0;
		map_req.bank       = 2'd0;
		map_drop           = 1'b0;

		if (|dl_byte.index) begin
			map_req.addr[22]    = page_eff[8];
			map_req.addr[21:14] = page_eff[7:0] + dl_byte.addr[21:14];
			map_req.bank        = {1'b0, &dl_byte.index[7:6]};
		end else begin
			// System ROM image, one 16K block per page
			case (dl_byte.addr[24:14])
				11'd0, 11'd4: map_req.addr[22:14] = page_sys_lower;
				11'd1, 11'd5: map_req.addr[22:14] = page_sys_basic;
				11'd2, 11'd6: map_req.addr[22:14] = page_sys_amsdos;
				11'd3, 11'd7: map_req.addr[22:14] = page_mf2;
				default:      map_drop = 1'b1;
			endcase
			map_req.bank = {1'b0, dl_byte.addr[16]};  // Blocks 4..7 to bank 1
		end
	end

	// Copy into bank 1 as well for manual loads and boot.eXX files
	assign map_dup = (dl_byte.index[7:6] == 2'b01) || (|dl_byte.index[5:0]);

	////////////////////////////////////////////////////////////
	// Handshake with the host and the write gate
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait   <= 1'b0;
			req_valid <= 1'b0;
			dup_q     <= 1'b0;
			drop_q    <= 1'b0;
			start_q   <= '0;
			run_page  <= '0;
			run_combo <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			drop_q    <= accept && map_drop;

			if (start_new) begin
				start_q   <= start;
				run_page  <= start.page;
				run_combo <= start.combo;
			end

			if (accept) begin
				dl_wait <= 1'b1;
				if (!map_drop) begin
					req_valid <= 1'b1;
					dup_q     <= map_dup;
				end
			end else if (drop_q) begin
				dl_wait <= 1'b0;  // Nothing written for this byte
			end else if (second_wr) begin
				req_valid <= 1'b1;
			end else if (last_done) begin
				dl_wait <= 1'b0;
				// MF2 image follows the last byte of the expansion ROM
				if (combo_eff && (&req.addr[13:0])) begin
					run_page  <= page_mf2;
					run_combo <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept && !map_drop)
			req <= map_req;
		else if (second_wr)
			req.bank <= 2'd1;
	end

endmodule

/* source/write_credit_gate.sv */
`timescale 1ns/1ps

module write_credit_gate import rom_loader_pkg::*; #(
	parameter int credit_max = 4
) (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    req_valid,
	input  mem_wr_t req,
	input  logic    mem_credit,
	output logic    req_done,
	output logic    mem_wr_valid,
	output mem_wr_t mem_wr
);

	localparam int cnt_w = $clog2(credit_max + 1);

	logic [cnt_w-1:0] credits;
	logic [cnt_w-1:0] credits_next;
	logic             pend_valid;
	mem_wr_t          pend;
	logic             have_req;
	mem_wr_t          cur;
	logic             fire;

	assign have_req = req_valid || pend_valid;
	assign cur      = req_valid ? req : pend;
	assign fire     = have_req && (credits != '0);  // Spend a credit this cycle

	// Issue and return together cancel out
	always_comb begin
		credits_next = credits;
		if (fire && !mem_credit)
			credits_next = credits - 1'b1;
		else if (!fire && mem_credit)
			credits_next = credits + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits      <= cnt_w'(credit_max);
			pend_valid   <= 1'b0;
			mem_wr_valid <= 1'b0;
			req_done     <= 1'b0;
		end else begin
			credits      <= credits_next;
			pend_valid   <= have_req && !fire;  // Held until a credit comes back
			mem_wr_valid <= fire;
			req_done     <= fire;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_valid)
			pend <= req;
		if (fire)
			mem_wr <= cur;
	end

endmodule

/* source/rom_map_table.sv */
`timescale 1ns/1ps

module rom_map_table import rom_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  mem_wr_valid,
	input  mem_wr_t               mem_wr,
	input  logic [mem_addr_w-1:0] query_addr,
	output logic                  rom_absent
);

	logic [255:0] rom_map;  // One flag per expansion ROM page
	logic         q_rom;    // Query falls in the ROM area
	logic [7:0]   q_page;

	////////////////////////////////////////////////////////////
	// Loaded page flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_map <= '0;
		end else if (mem_wr_valid && mem_wr.addr[22]) begin
			rom_map[mem_wr.addr[21:14]] <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Query
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			q_rom <= 1'b0;
		else
			q_rom <= query_addr[22];
	end

	always_ff @(posedge clk_sys) begin
		q_page <= query_addr[21:14];
	end

	assign rom_absent = q_rom && !rom_map[q_page];  // Unloaded page reads as absent

endmodule

/* source/rom_loader_top.sv */
`timescale 1ns/1ps

module rom_loader_top import rom_loader_pkg::*; #(
	parameter int credit_max = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	// Host download stream
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  dl_byte_t              dl_byte,
	input  logic [15:0]           dl_ext,
	output logic                  dl_wait,

	// SDRAM write side
	input  logic                  mem_credit,
	output logic                  mem_wr_valid,
	output mem_wr_t               mem_wr,

	// ROM presence query
	input  logic [mem_addr_w-1:0] query_addr,
	output logic                  rom_absent
);

	start_page_t start;
	logic        req_valid;
	mem_wr_t     req;
	logic        req_done;

	rom_ext_decode u_ext_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_byte.index),
		.dl_ext    (dl_ext),
		.start     (start)
	);

	rom_boot_mapper u_boot_mapper (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_wr     (dl_wr),
		.dl_byte   (dl_byte),
		.start     (start),
		.req_done  (req_done),
		.dl_wait   (dl_wait),
		.req_valid (req_valid),
		.req       (req)
	);

	////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////

	write_credit_gate #(
		.credit_max (credit_max)
	) u_credit_gate (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.req_valid    (req_valid),
		.req          (req),
		.mem_credit   (mem_credit),
		.req_done     (req_done),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr)
	);

	// Snoops the issued writes
	rom_map_table u_map_table (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr),
		.query_addr   (query_addr),
		.rom_absent   (rom_absent)
	);

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model import rom_loader_pkg::*; #(
	parameter int max_delay = 6,   // Longest gap between two returned credits
	parameter int log_depth = 64
) (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    mem_wr_valid,
	input  mem_wr_t mem_wr,
	input  logic    hold,         // Withhold every credit while high
	output logic    mem_credit,
	output int      outstanding,  // Writes whose credit has not gone back yet
	output int      wr_count
);

	mem_wr_t     wr_log [0:log_depth-1];  // Every write seen, in arrival order
	logic [31:0] seed;
	int          gap;

	// LCG step for the credit return delay
	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		mem_credit  = 1'b0;
		outstanding = 0;
		wr_count    = 0;
	end

	always @(posedge clk_sys) begin
		logic ret;
		ret = 1'b0;
		if (reset) begin
			seed        <= 32'hdbb2_602b;
			gap         <= 1;
			mem_credit  <= 1'b0;
			outstanding <= 0;
			wr_count    <= 0;
		end else begin
			// Credits go back one at a time, each after a random gap
			if (!hold && outstanding > 0) begin
				if (gap <= 1) begin
					ret = 1'b1;
					seed <= next_random(seed);
					gap  <= 1 + int'(seed[23:16]) % max_delay;
				end else begin
					gap <= gap - 1;
				end
			end
			mem_credit  <= ret;
			outstanding <= outstanding + int'(mem_wr_valid) - int'(ret);
			if (mem_wr_valid && wr_count < log_depth)
				wr_log[wr_count] <= mem_wr;
			if (mem_wr_valid)
				wr_count <= wr_count + 1;
		end
	end

endmodule

/* tb/tb_rom_loader.sv */
`timescale 1ns/1ps

module tb_rom_loader import rom_loader_pkg::*; ();

	localparam int credit_max   = 4;
	localparam int max_delay    = 6;
	localparam int n_stim       = 21;
	localparam int n_query      = 8;
	localparam int stall_cycles = 16;  // Cycles of held credits before they resume
	localparam int margin       = 10;
	localparam int cycle_limit  = (n_stim + n_query) * max_delay * margin;

	// One host byte and the writes it must produce
	typedef struct packed {
		logic [15:0]           ext;
		logic [7:0]            index;
		logic [24:0]           addr;
		logic [7:0]            data;
		logic                  hold;      // Credits withheld from this byte on
		logic [1:0]            n_exp;     // Second write always goes to bank 1
		logic [mem_addr_w-1:0] exp_addr;
		logic [1:0]            exp_bank;
	} stim_t;

	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic                  absent;
	} query_t;

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic                  dl_active;
	logic                  dl_wr;
	dl_byte_t              dl_byte;
	logic [15:0]           dl_ext;
	logic                  dl_wait;
	logic                  mem_credit;
	logic                  mem_wr_valid;
	mem_wr_t               mem_wr;
	logic [mem_addr_w-1:0] query_addr;
	logic                  rom_absent;
	logic                  mem_hold;
	int                    outstanding;
	int                    wr_count;

	stim_t  stim  [0:n_stim-1];
	query_t query [0:n_query-1];
	int     checks     = 0;
	int     errors     = 0;
	int     cycles     = 0;
	int     rd_idx     = 0;   // Next logged write to compare
	logic   stall_seen = 1'b0;

	rom_loader_top #(
		.credit_max (credit_max)
	) dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_byte      (dl_byte),
		.dl_ext       (dl_ext),
		.dl_wait      (dl_wait),
		.mem_credit   (mem_credit),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr),
		.query_addr   (query_addr),
		.rom_absent   (rom_absent)
	);

	tb_mem_model #(
		.max_delay (max_delay)
	) mem_model (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr),
		.hold         (mem_hold),
		.mem_credit   (mem_credit),
		.outstanding  (outstanding),
		.wr_count     (wr_count)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("test failed");
			$finish;
		end
	end

	// Credits held plus writes in flight stay within the limit
	always @(negedge clk_sys) begin
		if (!reset) begin
			assert (outstanding <= credit_max) else begin
				$display("FAIL %0t: %0d writes outstanding, limit is %0d",
					$time, outstanding, credit_max);
				errors++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tables
	////////////////////////////////////////////////////////////

	task automatic load_tables();
		// ext, index, byte addr, data, hold, writes, first write addr, first bank
		stim[0]  = '{"RM", 8'h00, 25'h000_0123, 8'h11, 1'b0, 2'd1, 23'h00_0123, 2'd0};
		stim[1]  = '{"RM", 8'h00, 25'h000_4010, 8'h12, 1'b0, 2'd1, 23'h40_0010, 2'd0};
		stim[2]  = '{"RM", 8'h00, 25'h000_8020, 8'h13, 1'b0, 2'd1, 23'h41_C020, 2'd0};
		stim[3]  = '{"RM", 8'h00, 25'h000_C030, 8'h14, 1'b0, 2'd1, 23'h7F_C030, 2'd0};
		stim[4]  = '{"RM", 8'h00, 25'h001_3FFF, 8'h15, 1'b0, 2'd1, 23'h00_3FFF, 2'd1};
		stim[5]  = '{"RM", 8'h00, 25'h001_4001, 8'h16, 1'b0, 2'd1, 23'h40_0001, 2'd1};
		stim[6]  = '{"RM", 8'h00, 25'h001_8002, 8'h17, 1'b0, 2'd1, 23'h41_C002, 2'd1};
		stim[7]  = '{"RM", 8'h00, 25'h001_C003, 8'h18, 1'b0, 2'd1, 23'h7F_C003, 2'd1};
		stim[8]  = '{"RM", 8'h00, 25'h002_0000, 8'h19, 1'b0, 2'd0, 23'h00_0000, 2'd0};
		stim[9]  = '{"3C", 8'h01, 25'h000_4005, 8'h21, 1'b0, 2'd2, 23'h4F_4005, 2'd0};
		stim[10] = '{"3C", 8'h01, 25'h000_0000, 8'h22, 1'b0, 2'd2, 23'h4F_0000, 2'd0};
		stim[11] = '{"3C", 8'hC0, 25'h000_0042, 8'h23, 1'b0, 2'd1, 23'h4F_0042, 2'd1};
		stim[12] = '{"3C", 8'h40, 25'h000_8000, 8'h24, 1'b0, 2'd2, 23'h4F_8000, 2'd0};
		stim[13] = '{"ZZ", 8'h01, 25'h000_4100, 8'h31, 1'b0, 2'd2, 23'h00_4100, 2'd0};
		stim[14] = '{"Z0", 8'h01, 25'h000_3FFF, 8'h32, 1'b0, 2'd2, 23'h00_3FFF, 2'd0};
		stim[15] = '{"Z0", 8'h01, 25'h000_0010, 8'h33, 1'b0, 2'd2, 23'h7F_C010, 2'd0};
		stim[16] = '{"QQ", 8'h01, 25'h000_0007, 8'h41, 1'b0, 2'd2, 23'h7B_8007, 2'd0};
		stim[17] = '{"3C", 8'h01, 25'h000_0100, 8'h51, 1'b1, 2'd2, 23'h4F_0100, 2'd0};
		stim[18] = '{"3C", 8'h01, 25'h000_4200, 8'h52, 1'b1, 2'd2, 23'h4F_4200, 2'd0};
		stim[19] = '{"3C", 8'h01, 25'h000_8300, 8'h53, 1'b1, 2'd2, 23'h4F_8300, 2'd0};
		stim[20] = '{"3C", 8'h01, 25'h000_C000, 8'h54, 1'b0, 2'd2, 23'h4F_C000, 2'd0};
		query[0] = '{23'h4F_0000, 1'b0};  // Page 13C loaded
		query[1] = '{23'h7B_8123, 1'b0};
		query[2] = '{23'h40_0000, 1'b0};
		query[3] = '{23'h7F_C010, 1'b0};
		query[4] = '{23'h50_0000, 1'b1};  // Page 140 never written
		query[5] = '{23'h40_4000, 1'b1};  // Page 001 holds data but page 101 does not
		query[6] = '{23'h10_0000, 1'b0};  // Outside the ROM area
		query[7] = '{23'h3F_C000, 1'b0};
	endtask

	////////////////////////////////////////////////////////////
	// Host side and checking
	////////////////////////////////////////////////////////////

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
			input string what);
		checks++;
		assert (got == want) else begin
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, want);
			errors++;
		end
	endtask

	// Restart the download so the decoder sees a new file
	task automatic open_download(input logic [15:0] ext, input logic [7:0] index);
		dl_active = 1'b0;
		@(negedge clk_sys);
		dl_ext        = ext;
		dl_byte.index = index;
		dl_active     = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic send_byte(input stim_t e);
		int stall_cnt;
		stall_cnt = 0;
		while (dl_wait)
			@(negedge clk_sys);
		dl_byte.addr = e.addr;
		dl_byte.data = e.data;
		dl_wr        = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		expect_equal(dl_wait, 1'b1, "dl_wait after dl_wr");
		while (dl_wait) begin
			if (mem_hold) begin
				stall_cnt++;
				if (stall_cnt >= stall_cycles) begin
					mem_hold   = 1'b0;  // Credits flow again
					stall_seen = 1'b1;
				end
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic check_writes(input int i);
		mem_wr_t got;
		int      n;
		int      k;
		n = wr_count - rd_idx;
		expect_equal(n, stim[i].n_exp, "write count");
		for (k = 0; k < n && k < stim[i].n_exp; k++) begin
			got = mem_model.wr_log[rd_idx + k];
			expect_equal(got.addr, stim[i].exp_addr, "write address");
			expect_equal(got.bank, (k == 0) ? stim[i].exp_bank : 2'd1, "write bank");
			expect_equal(got.data, stim[i].data, "write data");
		end
		rd_idx = wr_count;
	endtask

	initial begin
		int   i;
		int   err_before;
		logic prev_hold;
		logic prev_absent;
		reset       = 1'b1;
		dl_active   = 1'b0;
		dl_wr       = 1'b0;
		dl_byte     = '0;
		dl_ext      = '0;
		query_addr  = '0;
		mem_hold    = 1'b0;
		prev_hold   = 1'b0;
		prev_absent = 1'b0;
		load_tables();
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		for (i = 0; i < n_stim; i++) begin
			err_before = errors;
			if (stim[i].hold && !prev_hold) begin
				while (outstanding != 0)
					@(negedge clk_sys);
				@(negedge clk_sys);
				mem_hold = 1'b1;
			end
			if (!stim[i].hold)
				mem_hold = 1'b0;
			prev_hold = stim[i].hold;
			if (!dl_active || stim[i].ext != dl_ext || stim[i].index != dl_byte.index)
				open_download(stim[i].ext, stim[i].index);
			send_byte(stim[i]);
			check_writes(i);
			$display("stim %2d ext %s idx %h addr %h: %s", i, stim[i].ext, stim[i].index,
				stim[i].addr, (errors == err_before) ? "ok" : "mismatch");
		end
		checks++;
		assert (stall_seen) else begin
			$display("Withheld credits never held dl_wait high");
			errors++;
		end

		dl_active = 1'b0;
		for (i = 0; i < n_query; i++) begin
			err_before = errors;
			query_addr = query[i].addr;
			#1;
			// Answer still belongs to the previous query until the next edge
			expect_equal(rom_absent, prev_absent, "rom_absent before the edge");
			@(negedge clk_sys);
			expect_equal(rom_absent, query[i].absent, "rom_absent");
			prev_absent = query[i].absent;
			$display("query %0d addr %h: %s", i, query[i].addr,
				(errors == err_before) ? "ok" : "mismatch");
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
source/rom_loader_pkg.sv
source/rom_ext_decode.sv
source/rom_boot_mapper.sv
source/write_credit_gate.sv
source/rom_map_table.sv
source/rom_loader_top.sv
tb/tb_mem_model.sv
tb/tb_rom_loader.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_rom_loader
FILELIST  = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
